//--- verilog/buffer_defines.svh
`default_nettype none

`ifndef BUFFER_DEFINES_SVH
`define BUFFER_DEFINES_SVH

// bits per sample word
`define BUF_DATA_WIDTH 16
// input channels, one memory bank per channel
`define BUF_CHANNELS 2
`define BUF_BANK_DEPTH 64
// registered stages between read request and read data
`define BUF_READ_LATENCY 2

`endif

`default_nettype wire

//--- verilog/buffer_cfg_pkg.sv
`default_nettype none

package buffer_cfg_pkg;

  // capture sequence, HOLD keeps the saved data until readout
  typedef enum logic [2:0] {
    IDLE,
    ARMED,
    SAVING,
    HOLD,
    READING
  } capture_state_t;

  // chained mode runs channel 0 through bank 0 and then bank 1
  typedef enum logic {
    SPLIT   = 1'b0,
    CHAINED = 1'b1
  } bank_mode_t;

  typedef logic [2:0] reg_addr_t;

  // command word: bit 2 arm, bit 1 start, bit 0 stop
  localparam reg_addr_t REG_CMD       = 3'd0;
  localparam reg_addr_t REG_MODE      = 3'd1;
  localparam reg_addr_t REG_CAP_RESET = 3'd2;
  localparam reg_addr_t REG_RD_RESET  = 3'd3;
  localparam reg_addr_t REG_RD_START  = 3'd4;
  localparam reg_addr_t REG_STATUS    = 3'd5;

endpackage

`default_nettype wire

//--- verilog/sample_pkg.sv
`include "buffer_defines.svh"
`default_nettype none

package sample_pkg;

  typedef logic [`BUF_DATA_WIDTH-1:0] sample_t;

  typedef logic [$clog2(`BUF_BANK_DEPTH)-1:0] bank_addr_t;

  // one extra bit so a full bank can be counted
  typedef logic [$clog2(`BUF_BANK_DEPTH):0] depth_t;

endpackage

`default_nettype wire

//--- verilog/bank_port_if.sv
`timescale 1ns/1ns
`include "buffer_defines.svh"
`default_nettype none

interface bank_port_if;

  // write side, one shared address for all banks
  logic [`BUF_CHANNELS-1:0]                  wr_en;
  sample_pkg::bank_addr_t                    wr_addr;
  sample_pkg::sample_t [`BUF_CHANNELS-1:0]   wr_data;

  // read side
  logic                                      rd_en;
  logic [$clog2(`BUF_CHANNELS)-1:0]          rd_bank;
  sample_pkg::bank_addr_t                    rd_addr;
  sample_pkg::sample_t                       rd_data;
  logic                                      rd_valid;

  modport writer (output wr_en, output wr_addr, output wr_data);

  modport reader (output rd_en, output rd_bank, output rd_addr,
                  input rd_data, input rd_valid);

  modport banks (input wr_en, input wr_addr, input wr_data,
                 input rd_en, input rd_bank, input rd_addr,
                 output rd_data, output rd_valid);

endinterface

`default_nettype wire

//--- verilog/capture_regs.sv
`timescale 1ns/1ns
`default_nettype none

module capture_regs (
  input  logic                           ps_clk,
  input  logic                           rst_n_i,
  input  logic                           cfg_wr_i,
  input  buffer_cfg_pkg::reg_addr_t      cfg_addr_i,
  input  logic [7:0]                     cfg_wdata_i,
  input  buffer_cfg_pkg::capture_state_t state_i,
  input  logic                           full_i,
  output logic [7:0]                     cfg_rdata_o,
  output buffer_cfg_pkg::bank_mode_t     bank_mode_o,
  output logic                           arm_o,
  output logic                           start_o,
  output logic                           stop_o,
  output logic                           cap_reset_o,
  output logic                           rd_reset_o,
  output logic                           rd_start_o
);

  logic cmd_wr;

  assign cmd_wr = cfg_wr_i && (cfg_addr_i == buffer_cfg_pkg::REG_CMD);

  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      bank_mode_o <= buffer_cfg_pkg::SPLIT;
      arm_o       <= 1'b0;
      start_o     <= 1'b0;
      stop_o      <= 1'b0;
      cap_reset_o <= 1'b0;
      rd_reset_o  <= 1'b0;
      rd_start_o  <= 1'b0;
    end else begin
      // every command lasts exactly one cycle
      arm_o       <= cmd_wr && cfg_wdata_i[2];
      start_o     <= cmd_wr && cfg_wdata_i[1];
      stop_o      <= cmd_wr && cfg_wdata_i[0];
      cap_reset_o <= cfg_wr_i && (cfg_addr_i == buffer_cfg_pkg::REG_CAP_RESET);
      rd_reset_o  <= cfg_wr_i && (cfg_addr_i == buffer_cfg_pkg::REG_RD_RESET);
      rd_start_o  <= cfg_wr_i && (cfg_addr_i == buffer_cfg_pkg::REG_RD_START);
      // banking can only change between captures
      if (cfg_wr_i && (cfg_addr_i == buffer_cfg_pkg::REG_MODE) &&
          (state_i == buffer_cfg_pkg::IDLE)) begin
        bank_mode_o <= buffer_cfg_pkg::bank_mode_t'(cfg_wdata_i[0]);
      end
    end
  end

  always_comb begin
    case (cfg_addr_i)
      buffer_cfg_pkg::REG_MODE:   cfg_rdata_o = {7'd0, bank_mode_o};
      buffer_cfg_pkg::REG_STATUS: cfg_rdata_o = {4'd0, full_i, state_i};
      default:                    cfg_rdata_o = 8'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/sample_capture.sv
`timescale 1ns/1ns
`include "buffer_defines.svh"
`default_nettype none

module sample_capture (
  input  logic                                    ps_clk,
  input  logic                                    rst_n_i,
  input  buffer_cfg_pkg::bank_mode_t              bank_mode_i,
  input  logic                                    arm_i,
  input  logic                                    start_i,
  input  logic                                    stop_i,
  input  logic                                    cap_reset_i,
  input  logic                                    rd_start_i,
  input  logic                                    rd_reset_i,
  input  logic                                    rd_done_i,
  input  logic                                    hw_start_i,
  input  logic                                    hw_stop_i,
  input  logic                                    sample_valid_i,
  input  sample_pkg::sample_t [`BUF_CHANNELS-1:0] sample_data_i,
  bank_port_if.writer                             wp,
  output buffer_cfg_pkg::capture_state_t          state_o,
  output logic                                    full_o,
  output logic                                    depth_valid_o,
  output sample_pkg::depth_t [`BUF_CHANNELS-1:0]  depth_o,
  output logic                                    reading_o
);

  localparam sample_pkg::bank_addr_t LAST_ADDR =
    sample_pkg::bank_addr_t'(`BUF_BANK_DEPTH - 1);

  buffer_cfg_pkg::capture_state_t         state_q;
  buffer_cfg_pkg::capture_state_t         state_d;
  sample_pkg::bank_addr_t                 wr_addr_q;
  sample_pkg::depth_t [`BUF_CHANNELS-1:0] cnt_q;
  logic [`BUF_CHANNELS-1:0]               wr_en;
  logic                                   bank_sel_q;
  logic                                   full_q;
  logic                                   write_now;
  logic                                   full_hit;

  assign write_now = (state_q == buffer_cfg_pkg::SAVING) && sample_valid_i && !cap_reset_i;
  // last free word: end of bank 0 in split mode, end of bank 1 when chained
  assign full_hit  = write_now && (wr_addr_q == LAST_ADDR) &&
                     ((bank_mode_i == buffer_cfg_pkg::SPLIT) || bank_sel_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      buffer_cfg_pkg::IDLE: begin
        if (start_i) state_d = buffer_cfg_pkg::SAVING;
        else if (arm_i) state_d = buffer_cfg_pkg::ARMED;
      end
      buffer_cfg_pkg::ARMED: begin
        if (start_i || hw_start_i) state_d = buffer_cfg_pkg::SAVING;
      end
      buffer_cfg_pkg::SAVING: begin
        if (full_hit || stop_i || hw_stop_i) state_d = buffer_cfg_pkg::HOLD;
      end
      buffer_cfg_pkg::HOLD: begin
        if (rd_start_i && (|cnt_q)) state_d = buffer_cfg_pkg::READING;
      end
      buffer_cfg_pkg::READING: begin
        if (rd_reset_i) state_d = buffer_cfg_pkg::HOLD;
        else if (rd_done_i) state_d = buffer_cfg_pkg::IDLE;
      end
      default: state_d = buffer_cfg_pkg::IDLE;
    endcase
    if (cap_reset_i) state_d = buffer_cfg_pkg::IDLE;
  end

  // chained mode copies channel 0 to both banks and enables only one
  always_comb begin
    wr_en = '0;
    if (write_now) begin
      if (bank_mode_i == buffer_cfg_pkg::SPLIT) wr_en = '1;
      else wr_en[bank_sel_q] = 1'b1;
    end
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      wp.wr_data[b] = (bank_mode_i == buffer_cfg_pkg::SPLIT) ? sample_data_i[b]
                                                            : sample_data_i[0];
    end
  end

  assign wp.wr_en   = wr_en;
  assign wp.wr_addr = wr_addr_q;

  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      state_q       <= buffer_cfg_pkg::IDLE;
      wr_addr_q     <= '0;
      bank_sel_q    <= 1'b0;
      cnt_q         <= '0;
      full_q        <= 1'b0;
      depth_valid_o <= 1'b0;
    end else begin
      state_q       <= state_d;
      // report only on the way out of SAVING, never after a readout reset
      depth_valid_o <= (state_q == buffer_cfg_pkg::SAVING) &&
                       (state_d == buffer_cfg_pkg::HOLD);
      if (cap_reset_i || ((state_q != buffer_cfg_pkg::SAVING) &&
                          (state_d == buffer_cfg_pkg::SAVING))) begin
        wr_addr_q  <= '0;
        bank_sel_q <= 1'b0;
        cnt_q      <= '0;
      end else if (write_now) begin
        for (int b = 0; b < `BUF_CHANNELS; b++) begin
          if (wr_en[b]) cnt_q[b] <= cnt_q[b] + 1'b1;
        end
        wr_addr_q <= wr_addr_q + 1'b1;
        if (wr_addr_q == LAST_ADDR) bank_sel_q <= 1'b1;
      end
      if (full_hit) begin
        full_q <= 1'b1;
      end else if ((state_q == buffer_cfg_pkg::HOLD) && (state_d != buffer_cfg_pkg::HOLD)) begin
        full_q <= 1'b0;
      end
      if (cap_reset_i) full_q <= 1'b0;
    end
  end

  assign state_o   = state_q;
  assign full_o    = full_q;
  assign depth_o   = cnt_q;
  assign reading_o = (state_q == buffer_cfg_pkg::READING);

endmodule

`default_nettype wire

//--- verilog/sample_banks.sv
`timescale 1ns/1ns
`include "buffer_defines.svh"
`default_nettype none

module sample_banks (
  input logic       ps_clk,
  input logic       rst_n_i,
  bank_port_if.banks bp
);

  localparam int LAT = `BUF_READ_LATENCY;

  sample_pkg::sample_t mem [`BUF_CHANNELS][`BUF_BANK_DEPTH];
  sample_pkg::sample_t data_pipe [LAT];
  logic [LAT-1:0]      valid_pipe;

  always_ff @(posedge ps_clk) begin
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      if (bp.wr_en[b]) begin
        mem[b][bp.wr_addr] <= bp.wr_data[b];
      end
    end
  end

  // stage 0 is the array read, later stages only delay it
  always_ff @(posedge ps_clk) begin
    if (bp.rd_en) begin
      data_pipe[0] <= mem[bp.rd_bank][bp.rd_addr];
    end
    for (int s = 1; s < LAT; s++) begin
      data_pipe[s] <= data_pipe[s-1];
    end
  end

  // one valid bit per stage, so back-to-back reads overlap
  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe[0] <= bp.rd_en;
      for (int s = 1; s < LAT; s++) begin
        valid_pipe[s] <= valid_pipe[s-1];
      end
    end
  end

  assign bp.rd_data  = data_pipe[LAT-1];
  assign bp.rd_valid = valid_pipe[LAT-1];

endmodule

`default_nettype wire

//--- verilog/buffer_readout.sv
`timescale 1ns/1ns
`include "buffer_defines.svh"
`default_nettype none

module buffer_readout (
  input  logic                                   ps_clk,
  input  logic                                   rst_n_i,
  input  logic                                   reading_i,
  input  logic                                   rd_reset_i,
  input  sample_pkg::depth_t [`BUF_CHANNELS-1:0] depth_i,
  input  logic                                   out_ready_i,
  bank_port_if.reader                            rp,
  output logic                                   rd_done_o,
  output logic                                   out_valid_o,
  output sample_pkg::sample_t                    out_data_o,
  output logic                                   out_last_o
);

  localparam int QSIZE = `BUF_READ_LATENCY + 2;
  localparam int PW    = $clog2(QSIZE);
  localparam int CW    = $clog2(QSIZE + 1);

  sample_pkg::sample_t                   q_mem [QSIZE];
  logic [PW-1:0]                         wr_ptr_q;
  logic [PW-1:0]                         rd_ptr_q;
  logic [CW-1:0]                         q_cnt_q;
  logic [CW-1:0]                         inflight_q;
  // returns still owed from reads issued before a readout reset
  logic [CW-1:0]                         drop_q;
  logic [$bits(sample_pkg::depth_t):0]   left_q;
  sample_pkg::bank_addr_t                rd_addr_q;
  logic                                  rd_bank_q;
  logic                                  reading_d_q;
  logic                                  run_q;
  logic                                  issued_all_q;
  logic                                  bank_end;
  logic                                  final_issue;
  logic                                  issue;
  logic                                  push;
  logic                                  pop;

  assign bank_end    = ({1'b0, rd_addr_q} == depth_i[rd_bank_q] - 1'b1);
  assign final_issue = bank_end && (rd_bank_q || (depth_i[1] == '0));
  // reserve a queue slot for every read still in the memory pipeline
  assign issue = run_q && !rd_reset_i && !issued_all_q && ((inflight_q + q_cnt_q) < QSIZE);
  assign push  = rp.rd_valid && (drop_q == '0) && run_q && !rd_reset_i;
  assign pop   = out_valid_o && out_ready_i;

  assign rp.rd_en   = issue;
  assign rp.rd_bank = rd_bank_q;
  assign rp.rd_addr = rd_addr_q;

  assign out_valid_o = (q_cnt_q != '0);
  assign out_data_o  = q_mem[rd_ptr_q];
  assign out_last_o  = out_valid_o && (left_q == 1);

  always_ff @(posedge ps_clk) begin
    if (push) q_mem[wr_ptr_q] <= rp.rd_data;
  end

  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      reading_d_q  <= 1'b0;
      run_q        <= 1'b0;
      issued_all_q <= 1'b0;
      rd_bank_q    <= 1'b0;
      rd_addr_q    <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      q_cnt_q      <= '0;
      inflight_q   <= '0;
      drop_q       <= '0;
      left_q       <= '0;
      rd_done_o    <= 1'b0;
    end else begin
      reading_d_q <= reading_i;
      rd_done_o   <= 1'b0;
      inflight_q  <= inflight_q + CW'(issue) - CW'(rp.rd_valid);
      if (rd_reset_i) begin
        run_q    <= 1'b0;
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        q_cnt_q  <= '0;
        drop_q   <= inflight_q - CW'(rp.rd_valid);
      end else begin
        if (reading_i && !reading_d_q) begin
          run_q        <= 1'b1;
          issued_all_q <= 1'b0;
          rd_bank_q    <= 1'b0;
          rd_addr_q    <= '0;
          left_q       <= {1'b0, depth_i[0]} + {1'b0, depth_i[1]};
        end
        if (rp.rd_valid && (drop_q != '0)) drop_q <= drop_q - 1'b1;
        // walk bank 0 to its depth, then bank 1
        if (issue) begin
          if (final_issue) begin
            issued_all_q <= 1'b1;
          end else if (bank_end) begin
            rd_bank_q <= 1'b1;
            rd_addr_q <= '0;
          end else begin
            rd_addr_q <= rd_addr_q + 1'b1;
          end
        end
        if (push) wr_ptr_q <= (wr_ptr_q == PW'(QSIZE - 1)) ? '0 : wr_ptr_q + 1'b1;
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PW'(QSIZE - 1)) ? '0 : rd_ptr_q + 1'b1;
          left_q   <= left_q - 1'b1;
          if (left_q == 1) begin
            rd_done_o <= 1'b1;
            run_q     <= 1'b0;
          end
        end
        q_cnt_q <= q_cnt_q + CW'(push) - CW'(pop);
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/sample_buffer_top.sv
`timescale 1ns/1ns
`include "buffer_defines.svh"
`default_nettype none

module sample_buffer_top (
  input  logic                                         ps_clk,
  input  logic                                         rst_n_i,
  input  logic                                         cfg_wr_i,
  input  logic [2:0]                                   cfg_addr_i,
  input  logic [7:0]                                   cfg_wdata_i,
  output logic [7:0]                                   cfg_rdata_o,
  input  logic                                         sample_valid_i,
  input  logic [`BUF_CHANNELS*`BUF_DATA_WIDTH-1:0]     sample_data_i,
  input  logic                                         hw_start_i,
  input  logic                                         hw_stop_i,
  output logic                                         capture_full_o,
  output logic                                         depth_valid_o,
  output logic [`BUF_CHANNELS*($clog2(`BUF_BANK_DEPTH)+1)-1:0] depth_o,
  output logic                                         out_valid_o,
  input  logic                                         out_ready_i,
  output logic [`BUF_DATA_WIDTH-1:0]                   out_data_o,
  output logic                                         out_last_o
);

  buffer_cfg_pkg::capture_state_t         state;
  buffer_cfg_pkg::bank_mode_t             bank_mode;
  sample_pkg::depth_t [`BUF_CHANNELS-1:0] depth;
  logic                                   arm;
  logic                                   start;
  logic                                   stop;
  logic                                   cap_reset;
  logic                                   rd_reset;
  logic                                   rd_start;
  logic                                   rd_done;
  logic                                   reading;

  bank_port_if bank_port ();

  capture_regs regs_i (
    .ps_clk      (ps_clk),
    .rst_n_i     (rst_n_i),
    .cfg_wr_i    (cfg_wr_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .state_i     (state),
    .full_i      (capture_full_o),
    .cfg_rdata_o (cfg_rdata_o),
    .bank_mode_o (bank_mode),
    .arm_o       (arm),
    .start_o     (start),
    .stop_o      (stop),
    .cap_reset_o (cap_reset),
    .rd_reset_o  (rd_reset),
    .rd_start_o  (rd_start)
  );

  sample_capture capture_i (
    .ps_clk         (ps_clk),
    .rst_n_i        (rst_n_i),
    .bank_mode_i    (bank_mode),
    .arm_i          (arm),
    .start_i        (start),
    .stop_i         (stop),
    .cap_reset_i    (cap_reset),
    .rd_start_i     (rd_start),
    .rd_reset_i     (rd_reset),
    .rd_done_i      (rd_done),
    .hw_start_i     (hw_start_i),
    .hw_stop_i      (hw_stop_i),
    .sample_valid_i (sample_valid_i),
    .sample_data_i  (sample_data_i),
    .wp             (bank_port.writer),
    .state_o        (state),
    .full_o         (capture_full_o),
    .depth_valid_o  (depth_valid_o),
    .depth_o        (depth),
    .reading_o      (reading)
  );

  sample_banks banks_i (
    .ps_clk  (ps_clk),
    .rst_n_i (rst_n_i),
    .bp      (bank_port.banks)
  );

  buffer_readout readout_i (
    .ps_clk      (ps_clk),
    .rst_n_i     (rst_n_i),
    .reading_i   (reading),
    .rd_reset_i  (rd_reset),
    .depth_i     (depth),
    .out_ready_i (out_ready_i),
    .rp          (bank_port.reader),
    .rd_done_o   (rd_done),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_last_o  (out_last_o)
  );

  // bank 0 count in the low bits
  assign depth_o = depth;

endmodule

`default_nettype wire

//--- verification/sample_buffer_assertions.sv
`timescale 1ns/1ns
`include "buffer_defines.svh"
`default_nettype none

module sample_buffer_assertions (
  input logic                       ps_clk,
  input logic                       rst_n_i,
  input logic                       depth_valid_i,
  input logic                       capture_full_i,
  input logic [`BUF_CHANNELS-1:0]   bank_wr_en_i,
  input logic                       out_valid_i,
  input logic                       out_ready_i,
  input logic [`BUF_DATA_WIDTH-1:0] out_data_i,
  input logic                       out_last_i
);

  int fail_count = 0;

  // one report per capture, a single cycle wide
  a_single_report: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
    depth_valid_i |=> !depth_valid_i)
    else begin
      fail_count++;
      $error("depth report held for two cycles");
    end

  // a stalled word holds still unless a readout reset flushes the stream
  a_stall_stable: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
    (out_valid_i && !out_ready_i) |=>
      (!out_valid_i || ($stable(out_data_i) && $stable(out_last_i))))
    else begin
      fail_count++;
      $error("output word changed while stalled");
    end

  a_no_write_when_full: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
    capture_full_i |-> (bank_wr_en_i == '0))
    else begin
      fail_count++;
      $error("bank written while capture is full");
    end

endmodule

bind sample_buffer_top sample_buffer_assertions protocol_chk (
  .ps_clk         (ps_clk),
  .rst_n_i        (rst_n_i),
  .depth_valid_i  (depth_valid_o),
  .capture_full_i (capture_full_o),
  .bank_wr_en_i   (bank_port.wr_en),
  .out_valid_i    (out_valid_o),
  .out_ready_i    (out_ready_i),
  .out_data_i     (out_data_o),
  .out_last_i     (out_last_o)
);

`default_nettype wire

//--- verification/sample_buffer_tb.sv
`timescale 1ns/1ns
`include "buffer_defines.svh"
`default_nettype none

module sample_buffer_tb;

  localparam int DW    = `BUF_DATA_WIDTH;
  localparam int DEPTH = `BUF_BANK_DEPTH;
  localparam int CW    = $clog2(`BUF_BANK_DEPTH) + 1;
  // samples plus words of all five tests at about four cycles each with random ready
  localparam int TEST_WORDS = (40 + 80) + (25 + 50) + (128 + 128) + (45 + 12 + 60);
  localparam int MAX_CYCLES = TEST_WORDS * 4 + 1000;

  logic ps_clk = 1'b0;
  logic rst_n_i;
  logic cfg_wr_i;
  logic [2:0] cfg_addr_i;
  logic [7:0] cfg_wdata_i;
  logic [7:0] cfg_rdata_o;
  logic sample_valid_i;
  logic [`BUF_CHANNELS*DW-1:0] sample_data_i;
  logic hw_start_i;
  logic hw_stop_i;
  logic capture_full_o;
  logic depth_valid_o;
  logic [`BUF_CHANNELS*CW-1:0] depth_o;
  logic out_valid_o;
  logic out_ready_i;
  logic [DW-1:0] out_data_o;
  logic out_last_o;

  logic [31:0] lfsr;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int reports = 0;
  int base_reports = 0;
  logic [`BUF_CHANNELS*CW-1:0] report_depth;
  logic chained;
  // expected contents of bank 0 and bank 1 in readout order
  logic [DW-1:0] bank0_q[$];
  logic [DW-1:0] bank1_q[$];

  sample_buffer_top uut (.*);

  initial begin
    forever #4 ps_clk = ~ps_clk;
  end

  // depth reports are counted on the edge that ends their cycle
  always @(posedge ps_clk) begin
    if (rst_n_i && depth_valid_o) begin
      reports = reports + 1;
      report_depth = depth_o;
    end
  end

  always @(posedge ps_clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("run stopped by timeout after %0d cycles", cycles);
      errors = errors + 1;
      finish_run();
    end
  end

  task automatic finish_run();
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, uut.protocol_chk.fail_count);
    if ((errors == 0) && (uut.protocol_chk.fail_count == 0)) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors = errors + 1;
    $display("%s", msg);
  endtask

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge ps_clk);
  endtask

  task automatic reg_write(input logic [2:0] addr, input logic [7:0] data);
    cfg_wr_i = 1'b1;
    cfg_addr_i = addr;
    cfg_wdata_i = data;
    @(negedge ps_clk);
    cfg_wr_i = 1'b0;
  endtask

  // the pulse lands one cycle after the write and the state moves one cycle later
  task automatic send_command(input logic [2:0] addr, input logic [7:0] data);
    reg_write(addr, data);
    idle(1);
  endtask

  task automatic check_status(input logic [2:0] state, input logic full);
    cfg_addr_i = buffer_cfg_pkg::REG_STATUS;
    @(negedge ps_clk);
    expect_equal("cfg_rdata_o", cfg_rdata_o, {4'd0, full, state});
  endtask

  task automatic pulse_hw(input bit start);
    if (start) hw_start_i = 1'b1;
    else hw_stop_i = 1'b1;
    idle(1);
    hw_start_i = 1'b0;
    hw_stop_i = 1'b0;
  endtask

  task automatic new_capture();
    bank0_q.delete();
    bank1_q.delete();
    base_reports = reports;
  endtask

  task automatic drive_sample();
    logic [31:0] word;
    word = lfsr_bits(2 * DW);
    sample_data_i = word;
    sample_valid_i = 1'b1;
    if (!chained) begin
      bank0_q.push_back(word[DW-1:0]);
      bank1_q.push_back(word[2*DW-1:DW]);
    end else if (bank0_q.size() < DEPTH) begin
      bank0_q.push_back(word[DW-1:0]);
    end else begin
      bank1_q.push_back(word[DW-1:0]);
    end
    idle(1);
    sample_valid_i = 1'b0;
  endtask

  task automatic send_samples(input int n);
    repeat (n) drive_sample();
  endtask

  task automatic check_report(input int exp0, input int exp1);
    int waited;
    waited = 0;
    while ((reports == base_reports) && (waited < 10)) begin
      idle(1);
      waited++;
    end
    idle(2);
    if (reports != base_reports + 1) begin
      report_failure($sformatf("expected one depth report, saw %0d", reports - base_reports));
    end else begin
      expect_equal("depth_o bank 0", report_depth[CW-1:0], exp0);
      expect_equal("depth_o bank 1", report_depth[2*CW-1:CW], exp1);
    end
  endtask

  task automatic check_no_report();
    idle(4);
    if (reports != base_reports) begin
      report_failure("depth report seen where none was due");
    end
  endtask

  // accept count words and compare them with bank 0 then bank 1
  task automatic take_words(input int count, input bit random_ready);
    int idx;
    int waited;
    int total;
    logic [31:0] r;
    logic [DW-1:0] exp;
    idx = 0;
    waited = 0;
    total = bank0_q.size() + bank1_q.size();
    while ((idx < count) && (waited < 8 * total + 20)) begin
      out_ready_i = 1'b1;
      if (random_ready) begin
        r = lfsr_bits(1);
        out_ready_i = r[0];
      end
      if (out_valid_o && out_ready_i) begin
        exp = (idx < bank0_q.size()) ? bank0_q[idx] : bank1_q[idx - bank0_q.size()];
        expect_equal("out_data_o", out_data_o, exp);
        expect_equal("out_last_o", out_last_o, idx == total - 1);
        idx++;
      end
      idle(1);
      waited++;
    end
    out_ready_i = 1'b0;
    if (idx < count) begin
      report_failure($sformatf("readout stalled after %0d of %0d words", idx, count));
    end
  endtask

  task automatic read_all(input bit random_ready);
    send_command(buffer_cfg_pkg::REG_RD_START, 8'h00);
    take_words(bank0_q.size() + bank1_q.size(), random_ready);
    idle(3);
    expect_equal("out_valid_o", out_valid_o, 1'b0);
    check_status(buffer_cfg_pkg::IDLE, 1'b0);
  endtask

  task automatic software_capture_flow();
    new_capture();
    send_command(buffer_cfg_pkg::REG_CMD, 8'h02);
    send_samples(40);
    send_command(buffer_cfg_pkg::REG_CMD, 8'h01);
    check_report(40, 40);
    read_all(1'b0);
  endtask

  task automatic hw_start_arming();
    new_capture();
    // not armed, so the trigger is ignored
    pulse_hw(1'b1);
    check_no_report();
    check_status(buffer_cfg_pkg::IDLE, 1'b0);
    send_command(buffer_cfg_pkg::REG_RD_START, 8'h00);
    for (int i = 0; i < 8; i++) begin
      if (out_valid_o) report_failure("readout produced a word outside HOLD");
      idle(1);
    end
    send_command(buffer_cfg_pkg::REG_CMD, 8'h04);
    check_status(buffer_cfg_pkg::ARMED, 1'b0);
    pulse_hw(1'b1);
    send_samples(25);
    pulse_hw(1'b0);
    check_report(25, 25);
    read_all(1'b1);
  endtask

  task automatic chained_full_capture();
    int sent;
    reg_write(buffer_cfg_pkg::REG_MODE, 8'h01);
    chained = 1'b1;
    new_capture();
    send_command(buffer_cfg_pkg::REG_CMD, 8'h02);
    sent = 0;
    while (!capture_full_o && (sent < 2 * DEPTH + 8)) begin
      drive_sample();
      sent++;
    end
    expect_equal("samples before capture_full_o", sent, 2 * DEPTH);
    // samples offered while full must not reach the banks
    sample_data_i = lfsr_bits(2 * DW);
    sample_valid_i = 1'b1;
    idle(3);
    sample_valid_i = 1'b0;
    check_report(DEPTH, DEPTH);
    expect_equal("capture_full_o", capture_full_o, 1'b1);
    check_status(buffer_cfg_pkg::HOLD, 1'b1);
    read_all(1'b1);
  endtask

  task automatic capture_reset_recovery();
    reg_write(buffer_cfg_pkg::REG_MODE, 8'h00);
    chained = 1'b0;
    new_capture();
    send_command(buffer_cfg_pkg::REG_CMD, 8'h04);
    check_status(buffer_cfg_pkg::ARMED, 1'b0);
    send_command(buffer_cfg_pkg::REG_CAP_RESET, 8'h00);
    check_no_report();
    check_status(buffer_cfg_pkg::IDLE, 1'b0);
    send_command(buffer_cfg_pkg::REG_CMD, 8'h02);
    send_samples(15);
    send_command(buffer_cfg_pkg::REG_CAP_RESET, 8'h00);
    check_no_report();
    check_status(buffer_cfg_pkg::IDLE, 1'b0);
    new_capture();
    send_command(buffer_cfg_pkg::REG_CMD, 8'h02);
    send_samples(30);
    send_command(buffer_cfg_pkg::REG_CMD, 8'h01);
    check_report(30, 30);
  endtask

  // works on the data that the capture reset test left in HOLD
  task automatic readout_backpressure();
    send_command(buffer_cfg_pkg::REG_RD_START, 8'h00);
    take_words(12, 1'b1);
    send_command(buffer_cfg_pkg::REG_RD_RESET, 8'h00);
    idle(4);
    expect_equal("out_valid_o", out_valid_o, 1'b0);
    check_status(buffer_cfg_pkg::HOLD, 1'b0);
    read_all(1'b1);
  endtask

  initial begin
    rst_n_i = 1'b0;
    cfg_wr_i = 1'b0;
    cfg_addr_i = '0;
    cfg_wdata_i = '0;
    sample_valid_i = 1'b0;
    sample_data_i = '0;
    hw_start_i = 1'b0;
    hw_stop_i = 1'b0;
    out_ready_i = 1'b0;
    lfsr = 32'h77439819;
    chained = 1'b0;
    repeat (2) @(negedge ps_clk);
    rst_n_i = 1'b1;
    expect_equal("depth_valid_o", depth_valid_o, 1'b0);
    expect_equal("capture_full_o", capture_full_o, 1'b0);
    expect_equal("out_valid_o", out_valid_o, 1'b0);
    check_status(buffer_cfg_pkg::IDLE, 1'b0);
    software_capture_flow();
    hw_start_arming();
    chained_full_capture();
    capture_reset_recovery();
    readout_backpressure();
    finish_run();
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/buffer_cfg_pkg.sv
verilog/sample_pkg.sv
verilog/bank_port_if.sv
verilog/capture_regs.sv
verilog/sample_capture.sv
verilog/sample_banks.sv
verilog/buffer_readout.sv
verilog/sample_buffer_top.sv
verification/sample_buffer_assertions.sv
verification/sample_buffer_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := sample_buffer_tb
FILELIST   := src.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_TEXT  := All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
